//--- alu_macros.svh
// SIMD ALU global dimensions
// Data word width, LDPC lane geometry and the saturation limit
// shared by the package and the datapath modules

`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// Integer data word
`define ALU_XLEN 32

// LDPC lanes, signed bytes packed into one word
`define ALU_LANE_W 8
`define ALU_LANES (`ALU_XLEN / `ALU_LANE_W)

// Saturated results stay within -127 .. +127
`define ALU_SAT_MAX 127

`endif

//--- alu_pkg.sv
// SIMD ALU package
// Width types, the operation code and the request bundle seen
// at the top-level port

`include "alu_macros.svh"

package alu_pkg;

    // Widths with a meaning
    typedef logic [`ALU_XLEN-1:0]         xlen_t;
    typedef logic [`ALU_LANE_W-1:0]       lane_t;
    typedef logic [$clog2(`ALU_XLEN)-1:0] shamt_t;

    // --------------------
    // Operation codes
    // --------------------
    typedef enum logic [4:0] {
        // Integer set
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        // LDPC set, per signed byte lane
        OP_LDPC_SIGN,
        OP_LDPC_MIN,
        OP_LDPC_ABS,
        OP_LDPC_ADD_SAT,
        OP_LDPC_SUB_SAT,
        OP_LDPC_MINMAX,
        OP_LDPC_MIN_SORTING,
        OP_LDPC_RSIGN_NMESS
    } alu_op_e;

    // Issued request, operand_c only matters for three-operand LDPC ops
    typedef struct packed {
        alu_op_e op;
        xlen_t   operand_a;
        xlen_t   operand_b;
        xlen_t   operand_c;
    } alu_req_t;

endpackage

//--- alu_int_unit.sv
// Integer datapath of the SIMD ALU
// Shared adder for add/sub, bitwise logic, a single right shifter
// that also serves left shifts by bit reversal, and set-less-than.
// Purely combinational

`include "alu_macros.svh"

module alu_int_unit import alu_pkg::*; (
    input  alu_op_e op_i,
    input  xlen_t   operand_a_i,
    input  xlen_t   operand_b_i,
    output xlen_t   result_o
);

    // --------------------
    // Adder
    // --------------------
    logic                adder_negate;
    logic [`ALU_XLEN:0]  adder_in_a;
    logic [`ALU_XLEN:0]  adder_in_b;
    logic [`ALU_XLEN:0]  adder_sum;
    xlen_t               adder_result;

    assign adder_negate = (op_i == OP_SUB);

    // Carry-in rides in the extra LSB, inverted b plus one gives a - b
    assign adder_in_a   = {operand_a_i, 1'b1};
    assign adder_in_b   = {operand_b_i, 1'b0} ^ {(`ALU_XLEN+1){adder_negate}};
    assign adder_sum    = adder_in_a + adder_in_b;
    assign adder_result = adder_sum[`ALU_XLEN:1];

    // --------------------
    // Shifter
    // --------------------
    shamt_t              shamt;
    logic                shift_left;
    logic                shift_arith;
    xlen_t               operand_a_rev;
    xlen_t               shift_op_a;
    logic [`ALU_XLEN:0]  shift_op_ext;
    logic [`ALU_XLEN:0]  shift_right_result;
    xlen_t               shift_left_result;
    xlen_t               shift_result;

    assign shamt       = operand_b_i[$bits(shamt_t)-1:0];
    assign shift_left  = (op_i == OP_SLL);
    assign shift_arith = (op_i == OP_SRA);

    // Left shifts go through the right shifter on reversed bits
    for (genvar i = 0; i < `ALU_XLEN; i++) begin : gen_rev
        assign operand_a_rev[i]     = operand_a_i[`ALU_XLEN-1-i];
        assign shift_left_result[i] = shift_right_result[`ALU_XLEN-1-i];
    end

    assign shift_op_a   = shift_left ? operand_a_rev : operand_a_i;
    assign shift_op_ext = {shift_arith & shift_op_a[`ALU_XLEN-1], shift_op_a};

    assign shift_right_result = $unsigned($signed(shift_op_ext) >>> shamt);
    assign shift_result       = shift_left ? shift_left_result
                                           : shift_right_result[`ALU_XLEN-1:0];

    // --------------------
    // Comparison
    // --------------------
    logic is_signed;
    logic less;

    assign is_signed = (op_i == OP_SLT);
    // One extra sign bit turns the same compare into signed or unsigned
    assign less = $signed({is_signed & operand_a_i[`ALU_XLEN-1], operand_a_i}) <
                  $signed({is_signed & operand_b_i[`ALU_XLEN-1], operand_b_i});

    // Result select
    always_comb begin
        result_o = '0;
        case (op_i)
            OP_ADD, OP_SUB:         result_o = adder_result;
            OP_AND:                 result_o = operand_a_i & operand_b_i;
            OP_OR:                  result_o = operand_a_i | operand_b_i;
            OP_XOR:                 result_o = operand_a_i ^ operand_b_i;
            OP_SLL, OP_SRL, OP_SRA: result_o = shift_result;
            OP_SLT, OP_SLTU:        result_o = {{(`ALU_XLEN-1){1'b0}}, less};
            default:                result_o = '0;
        endcase
    end

endmodule

//--- ldpc_lane.sv
// One signed byte lane of the LDPC soft-decoding datapath
// Sign, min, abs, saturating add/sub, three-operand minmax,
// min-sorting and message sign correction. Combinational

`include "alu_macros.svh"

module ldpc_lane import alu_pkg::*; (
    input  alu_op_e op_i,
    input  lane_t   a_i,
    input  lane_t   b_i,
    input  lane_t   c_i,
    output lane_t   result_o
);

    localparam logic signed [`ALU_LANE_W:0] sat_pos = `ALU_SAT_MAX;
    localparam logic signed [`ALU_LANE_W:0] sat_neg = -`ALU_SAT_MAX;

    logic signed [`ALU_LANE_W-1:0] a_s;
    logic signed [`ALU_LANE_W-1:0] b_s;
    logic signed [`ALU_LANE_W-1:0] c_s;

    assign a_s = a_i;
    assign b_s = b_i;
    assign c_s = c_i;

    // --------------------
    // Saturating add/sub
    // --------------------
    // One guard bit is enough for a sum of two bytes
    logic signed [`ALU_LANE_W:0] sum_ext;
    logic signed [`ALU_LANE_W:0] diff_ext;
    lane_t                       add_sat;
    lane_t                       sub_sat;

    assign sum_ext  = a_s + b_s;
    assign diff_ext = a_s - b_s;

    assign add_sat = (sum_ext > sat_pos)  ? sat_pos[`ALU_LANE_W-1:0] :
                     (sum_ext < sat_neg)  ? sat_neg[`ALU_LANE_W-1:0] :
                                            sum_ext[`ALU_LANE_W-1:0];
    assign sub_sat = (diff_ext > sat_pos) ? sat_pos[`ALU_LANE_W-1:0] :
                     (diff_ext < sat_neg) ? sat_neg[`ALU_LANE_W-1:0] :
                                            diff_ext[`ALU_LANE_W-1:0];

    // --------------------
    // Compare based ops
    // --------------------
    lane_t min_ab;
    lane_t max_ab;
    lane_t minmax;
    lane_t abs_a;
    lane_t sorted;

    assign min_ab = (a_s >= b_s) ? b_i : a_i;
    assign max_ab = (b_s > a_s) ? b_i : a_i;
    // Max of a and b, capped by c
    assign minmax = ($signed(c_s) >= $signed(max_ab)) ? max_ab : c_i;
    // -128 wraps back onto itself
    assign abs_a  = (a_s >= 0) ? a_i : lane_t'(-a_s);
    assign sorted = (a_i != b_i) ? a_i : c_i;

    // Sign correction of the outgoing message
    logic  a_nonneg;
    lane_t rsign_x;
    lane_t rsign;

    assign a_nonneg = (a_s >= 0);
    assign rsign_x  = b_i ^ lane_t'(a_nonneg);
    assign rsign    = (rsign_x != '0) ? c_i : lane_t'(-c_s);

    always_comb begin
        case (op_i)
            OP_LDPC_SIGN:        result_o = lane_t'(a_s < 0);
            OP_LDPC_MIN:         result_o = min_ab;
            OP_LDPC_ABS:         result_o = abs_a;
            OP_LDPC_ADD_SAT:     result_o = add_sat;
            OP_LDPC_SUB_SAT:     result_o = sub_sat;
            OP_LDPC_MINMAX:      result_o = minmax;
            OP_LDPC_MIN_SORTING: result_o = sorted;
            OP_LDPC_RSIGN_NMESS: result_o = rsign;
            default:             result_o = '0;
        endcase
    end

endmodule

//--- alu_result_stage.sv
// Output stage of the SIMD ALU
// Picks the integer or LDPC word by operation class and holds it,
// together with its valid flag, for one cycle of latency

module alu_result_stage import alu_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    valid_i,
    input  alu_op_e op_i,
    input  xlen_t   int_result_i,
    input  xlen_t   ldpc_result_i,
    output xlen_t   result_o,
    output logic    valid_o
);

    xlen_t result_sel;
    xlen_t result_q;
    logic  valid_q;

    always_comb begin
        case (op_i)
            OP_LDPC_SIGN,
            OP_LDPC_MIN,
            OP_LDPC_ABS,
            OP_LDPC_ADD_SAT,
            OP_LDPC_SUB_SAT,
            OP_LDPC_MINMAX,
            OP_LDPC_MIN_SORTING,
            OP_LDPC_RSIGN_NMESS: result_sel = ldpc_result_i;
            default:             result_sel = int_result_i;
        endcase
    end

    // Result holds while idle, valid follows the issue strobe
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            result_q <= '0;
            valid_q  <= 1'b0;
        end else begin
            valid_q <= valid_i;
            if (valid_i) begin
                result_q <= result_sel;
            end
        end
    end

    assign result_o = result_q;
    assign valid_o  = valid_q;

endmodule

//--- alu_top.sv
// Registered SIMD integer ALU, top level
// Integer unit and four LDPC byte lanes run in parallel on each
// request, the result stage registers the selected word

`include "alu_macros.svh"

module alu_top import alu_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     valid_i,
    input  alu_req_t req_i,
    output xlen_t    result_o,
    output logic     valid_o
);

    xlen_t int_result;
    xlen_t ldpc_result;

    alu_int_unit u_int_unit (
        .op_i        (req_i.op),
        .operand_a_i (req_i.operand_a),
        .operand_b_i (req_i.operand_b),
        .result_o    (int_result)
    );

    // --------------------
    // LDPC lanes
    // --------------------
    for (genvar k = 0; k < `ALU_LANES; k++) begin : gen_lane
        ldpc_lane u_lane (
            .op_i     (req_i.op),
            .a_i      (req_i.operand_a[k*`ALU_LANE_W +: `ALU_LANE_W]),
            .b_i      (req_i.operand_b[k*`ALU_LANE_W +: `ALU_LANE_W]),
            .c_i      (req_i.operand_c[k*`ALU_LANE_W +: `ALU_LANE_W]),
            .result_o (ldpc_result[k*`ALU_LANE_W +: `ALU_LANE_W])
        );
    end

    alu_result_stage u_result_stage (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .valid_i       (valid_i),
        .op_i          (req_i.op),
        .int_result_i  (int_result),
        .ldpc_result_i (ldpc_result),
        .result_o      (result_o),
        .valid_o       (valid_o)
    );

endmodule

//--- alu_props.sv
// Timing properties of the SIMD ALU top level
// One-cycle valid latency, reset behavior and the saturation range

`include "alu_macros.svh"

module alu_props import alu_pkg::*; (
    input logic     clk_i,
    input logic     rst_i,
    input logic     valid_i,
    input alu_req_t req_i,
    input xlen_t    result_o,
    input logic     valid_o
);

    // True when some lane holds -128
    function automatic logic has_neg128(xlen_t w);
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < `ALU_LANES; k++) begin
            if (w[k*`ALU_LANE_W +: `ALU_LANE_W] == 8'h80) hit = 1'b1;
        end
        return hit;
    endfunction

    valid_follows_issue: assert property (@(posedge clk_i) disable iff (rst_i)
        !$past(rst_i) |-> valid_o == $past(valid_i))
        else $error("valid_o does not follow valid_i of the previous cycle");

    valid_low_after_reset: assert property (@(posedge clk_i)
        $past(rst_i) |-> !valid_o)
        else $error("valid_o high right after reset");

    sat_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
        (!$past(rst_i) && $past(valid_i) &&
         ($past(req_i.op) inside {OP_LDPC_ADD_SAT, OP_LDPC_SUB_SAT}))
        |-> !has_neg128(result_o))
        else $error("saturated lane left the -127 .. +127 range");

endmodule

bind alu_top alu_props u_props (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .valid_i  (valid_i),
    .req_i    (req_i),
    .result_o (result_o),
    .valid_o  (valid_o)
);

//--- tb_alu.sv
// Testbench for the registered SIMD ALU
// Random requests from an xorshift generator are checked against a
// behavioral model through a one-entry expected-result pipeline

`include "alu_macros.svh"

module tb_alu import alu_pkg::*; ();

    localparam int NUM_REQUESTS  = 3000;
    localparam int ISSUE_TIMEOUT = 20000;
    localparam int DRAIN_TIMEOUT = 10;
    localparam int RESET_TIMEOUT = 10;

    logic        clk;
    logic        rst;
    logic        req_valid;
    alu_req_t    req;
    xlen_t       dut_result;
    logic        dut_valid;

    logic [31:0] rng_state;
    logic        exp_valid;
    xlen_t       exp_result;
    int          issued;
    int          error_count;
    int          wait_cycles;

    alu_top u_dut (
        .clk_i    (clk),
        .rst_i    (rst),
        .valid_i  (req_valid),
        .req_i    (req),
        .result_o (dut_result),
        .valid_o  (dut_valid)
    );

    always #50 clk = ~clk;

    // --------------------
    // Random source
    // --------------------
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Magnitude 120 .. 128 with a random sign
    function automatic lane_t extreme_lane();
        logic [31:0] r;
        int          mag;
        r   = next_rand();
        mag = 120 + int'(r % 9);
        return r[16] ? lane_t'(-mag) : lane_t'(mag);
    endfunction

    function automatic alu_req_t random_request();
        alu_req_t    r;
        logic [4:0]  code;
        code          = 5'(next_rand() % 18);
        r.op          = alu_op_e'(code);
        r.operand_a   = next_rand();
        r.operand_b   = next_rand();
        r.operand_c   = next_rand();
        if (next_rand() % 4 == 0) begin
            for (int k = 0; k < `ALU_LANES; k++) begin
                r.operand_a[k*`ALU_LANE_W +: `ALU_LANE_W] = extreme_lane();
                r.operand_b[k*`ALU_LANE_W +: `ALU_LANE_W] = extreme_lane();
                r.operand_c[k*`ALU_LANE_W +: `ALU_LANE_W] = extreme_lane();
            end
        end
        // Equal lanes exercise MIN, MIN_SORTING and SUB_SAT corners
        if (next_rand() % 4 == 0) begin
            r.operand_b = r.operand_a;
        end
        return r;
    endfunction

    // --------------------
    // Reference model
    // --------------------
    function automatic xlen_t int_expected(alu_op_e op, xlen_t a, xlen_t b);
        int unsigned sh;
        sh = b[4:0];
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << sh;
            OP_SRL:  return a >> sh;
            OP_SRA:  return xlen_t'($signed(a) >>> sh);
            OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    function automatic lane_t lane_expected(alu_op_e op, lane_t a, lane_t b, lane_t c);
        int    sa;
        int    sb;
        int    sc;
        int    t;
        int    m;
        lane_t x;
        sa = $signed(a);
        sb = $signed(b);
        sc = $signed(c);
        case (op)
            OP_LDPC_SIGN: return (sa < 0) ? 8'd1 : 8'd0;
            OP_LDPC_MIN:  return (sa >= sb) ? b : a;
            OP_LDPC_ABS:  return lane_t'((sa < 0) ? -sa : sa);
            OP_LDPC_ADD_SAT, OP_LDPC_SUB_SAT: begin
                t = (op == OP_LDPC_ADD_SAT) ? sa + sb : sa - sb;
                if (t > `ALU_SAT_MAX) t = `ALU_SAT_MAX;
                else if (t < -`ALU_SAT_MAX) t = -`ALU_SAT_MAX;
                return lane_t'(t);
            end
            OP_LDPC_MINMAX: begin
                m = (sb > sa) ? sb : sa;
                return lane_t'((sc >= m) ? m : sc);
            end
            OP_LDPC_MIN_SORTING: return (a != b) ? a : c;
            OP_LDPC_RSIGN_NMESS: begin
                x = b ^ ((sa >= 0) ? 8'd1 : 8'd0);
                return (x != 8'd0) ? c : lane_t'(-sc);
            end
            default: return '0;
        endcase
    endfunction

    function automatic xlen_t expected_word(alu_req_t r);
        xlen_t w;
        if (r.op >= OP_LDPC_SIGN) begin
            for (int k = 0; k < `ALU_LANES; k++) begin
                w[k*`ALU_LANE_W +: `ALU_LANE_W] = lane_expected(r.op,
                    r.operand_a[k*`ALU_LANE_W +: `ALU_LANE_W],
                    r.operand_b[k*`ALU_LANE_W +: `ALU_LANE_W],
                    r.operand_c[k*`ALU_LANE_W +: `ALU_LANE_W]);
            end
        end else begin
            w = int_expected(r.op, r.operand_a, r.operand_b);
        end
        return w;
    endfunction

    // --------------------
    // Checks
    // --------------------
    task automatic abort_run(input string reason);
        $display("TB FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic report_timeout(input string which);
        $display("Timeout: gave up waiting for %s", which);
        abort_run("wait timed out");
    endtask

    task automatic check_result(input xlen_t got, input xlen_t exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("error: time %0t, %s is %h, expected %h", $time, what, got, exp);
            abort_run("result mismatch");
        end
    endtask

    task automatic check_valid(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            error_count++;
            $display("error: time %0t, %s is %b, expected %b", $time, what, got, exp);
            abort_run("valid mismatch");
        end
    endtask

    // Check the outputs of the last edge, then drive the next request
    task automatic run_cycle(input logic allow_issue);
        alu_req_t next_req;
        logic     next_valid;
        @(posedge clk);
        #10;
        check_valid(dut_valid, exp_valid, "valid_o");
        check_result(dut_result, exp_result, "result_o");
        next_req   = random_request();
        next_valid = allow_issue && (next_rand() % 4 != 0);
        req        = next_req;
        req_valid  = next_valid;
        exp_valid  = next_valid;
        if (next_valid) begin
            exp_result = expected_word(next_req);
            issued++;
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        rng_state   = 32'd89382;
        // Live request during reset, reset has to win over it
        req_valid   = 1'b1;
        req         = random_request();
        exp_valid   = 1'b0;
        exp_result  = '0;
        issued      = 0;
        error_count = 0;

        repeat (3) @(posedge clk);
        #10;
        rst       = 1'b0;
        req_valid = 1'b0;

        wait_cycles = 0;
        while (dut_valid !== 1'b0) begin
            @(posedge clk);
            #10;
            wait_cycles++;
            if (wait_cycles > RESET_TIMEOUT) report_timeout("reset release");
        end
        check_valid(dut_valid, 1'b0, "valid_o after reset");
        check_result(dut_result, '0, "result_o after reset");

        wait_cycles = 0;
        while (issued < NUM_REQUESTS) begin
            run_cycle(1'b1);
            wait_cycles++;
            if (wait_cycles > ISSUE_TIMEOUT) report_timeout("all requests to issue");
        end

        // Drain the last result, then one idle cycle to see it hold
        wait_cycles = 0;
        while (exp_valid) begin
            run_cycle(1'b0);
            wait_cycles++;
            if (wait_cycles > DRAIN_TIMEOUT) report_timeout("the final drain");
        end
        run_cycle(1'b0);

        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+.
alu_pkg.sv
alu_int_unit.sv
ldpc_lane.sv
alu_result_stage.sv
alu_top.sv
alu_props.sv
tb_alu.sv

//--- Bender.yml
package:
  name: simd_alu

sources:
  - include_dirs:
      - .
    files:
      - alu_pkg.sv
      - alu_int_unit.sv
      - ldpc_lane.sv
      - alu_result_stage.sv
      - alu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - alu_props.sv
      - tb_alu.sv
